// File: hdl/ppu_settings.svh
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// ==================================================
// Line and frame geometry
// ==================================================
`define PPU_DOTS_PER_LINE   456
`define PPU_LINES_PER_FRAME 154
`define PPU_VISIBLE_LINES   144
`define PPU_SCREEN_WIDTH    160
// Length of mode 2 at the start of each visible line
`define PPU_OAM_SCAN_DOTS   80

// ==================================================
// CPU address map
// ==================================================
`define PPU_VRAM_START 16'h8000
`define PPU_VRAM_END   16'h9FFF
`define PPU_REG_START  16'hFF40
`define PPU_REG_END    16'hFF4B
// OAM DMA register, not mapped here
`define PPU_DMA_ADDR   16'hFF46

// Background pixel FIFO entries
`define PPU_FIFO_DEPTH 16

`endif

// File: hdl/ppu_pkg.sv
package ppu_pkg;

  // ==================================================
  // Display and fetcher states
  // ==================================================

  // Encoding matches STAT bits 1:0
  typedef enum logic [1:0] {
    mode_hblank   = 2'd0,
    mode_vblank   = 2'd1,
    mode_oam_scan = 2'd2,
    mode_transfer = 2'd3
  } ppu_mode_t;

  // Background fetch steps
  typedef enum logic [1:0] {
    fetch_tile,
    fetch_low,
    fetch_high,
    fetch_push
  } fetch_state_t;

  // ==================================================
  // Widths
  // ==================================================
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] cpu_addr_t;
  typedef logic [12:0] vram_addr_t;
  typedef logic [8:0]  dot_t;
  typedef logic [1:0]  color_t;
  // Plane 1 in the high byte, MSB is the leftmost pixel
  typedef logic [15:0] tile_row_t;

endpackage

// File: hdl/ppu_ifs.sv
`timescale 1ns/100ps

// LCD register view shared by all blocks
interface ppu_regs_if import ppu_pkg::*; ();
  byte_t      lcdc;
  byte_t      scx;
  byte_t      scy;
  byte_t      bgp;
  byte_t      lyc;
  // STAT bits 6:3
  logic [3:0] stat_enable;
  byte_t      ly;
  ppu_mode_t  mode;
  logic       coincidence;

  modport cpu (output lcdc, scx, scy, bgp, lyc, stat_enable,
               input ly, mode, coincidence);
  modport timing (input lcdc, lyc, stat_enable,
                  output ly, mode, coincidence);
  modport reader (input lcdc, scx, scy, bgp, ly, mode);
endinterface

// Fetcher read port into VRAM, data one cycle after the request
interface vram_fetch_if import ppu_pkg::*; ();
  logic       read_req;
  vram_addr_t addr;
  byte_t      rdata;

  modport fetcher (output read_req, addr, input rdata);
  modport memory (input read_req, addr, output rdata);
endinterface

// Fetcher to FIFO to pixel output
interface pixel_fifo_if import ppu_pkg::*; ();
  logic      push;
  tile_row_t push_row;
  logic      room;
  logic      has_pixel;
  logic      pop;
  color_t    head;

  modport writer (output push, push_row, input room);
  modport store (input push, push_row, pop, output room, has_pixel, head);
  modport reader (input has_pixel, head, output pop);
endinterface

// File: hdl/ppu_cpu_port.sv
`timescale 1ns/100ps
`include "ppu_settings.svh"

module ppu_cpu_port import ppu_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  cpu_addr_t    cpu_addr,
  input  byte_t        cpu_wdata,
  input  logic         cpu_write_en,
  input  logic         cpu_read_en,
  output byte_t        cpu_rdata,
  ppu_regs_if.cpu      regs,
  vram_fetch_if.memory fetch
);

  localparam int vram_bytes = `PPU_VRAM_END - `PPU_VRAM_START + 1;

  // 8 KB video memory
  byte_t vram [vram_bytes];

  // Window position, stored and read back only
  byte_t wy;
  byte_t wx;

  logic       vram_sel;
  logic       reg_sel;
  logic       cpu_locked;
  vram_addr_t cpu_offset;

  // ==================================================
  // Address decode
  // ==================================================
  assign vram_sel = cpu_addr inside {[`PPU_VRAM_START : `PPU_VRAM_END]};
  assign reg_sel = (cpu_addr inside {[`PPU_REG_START : `PPU_REG_END]}) &&
                   (cpu_addr != `PPU_DMA_ADDR);
  assign cpu_offset = vram_addr_t'(cpu_addr - `PPU_VRAM_START);

  // CPU shut out of VRAM while pixels are fetched
  assign cpu_locked = (regs.mode == mode_transfer);

  // ==================================================
  // Register writes
  // ==================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs.lcdc        <= '0;
      regs.stat_enable <= '0;
      regs.scy         <= '0;
      regs.scx         <= '0;
      regs.lyc         <= '0;
      regs.bgp         <= '0;
      wy               <= '0;
      wx               <= '0;
    end else if (cpu_write_en && reg_sel) begin
      case (cpu_addr[3:0])
        4'h0: regs.lcdc <= cpu_wdata;
        // Only the interrupt enables are writable
        4'h1: regs.stat_enable <= cpu_wdata[6:3];
        4'h2: regs.scy <= cpu_wdata;
        4'h3: regs.scx <= cpu_wdata;
        4'h5: regs.lyc <= cpu_wdata;
        4'h7: regs.bgp <= cpu_wdata;
        4'hA: wy <= cpu_wdata;
        4'hB: wx <= cpu_wdata;
        // LY and sprite palettes ignore writes
        default: ;
      endcase
    end
  end

  // ==================================================
  // VRAM ports
  // ==================================================
  always_ff @(posedge clk) begin
    // CPU write, dropped during transfer
    if (cpu_write_en && vram_sel && !cpu_locked) begin
      vram[cpu_offset] <= cpu_wdata;
    end
    // Fetcher read, never blocked
    if (fetch.read_req) begin
      fetch.rdata <= vram[fetch.addr];
    end
  end

  // ==================================================
  // CPU read mux
  // ==================================================
  always_comb begin
    // Open bus by default
    cpu_rdata = 8'hFF;
    if (cpu_read_en) begin
      if (vram_sel) begin
        if (!cpu_locked) begin
          cpu_rdata = vram[cpu_offset];
        end
      end else if (reg_sel) begin
        case (cpu_addr[3:0])
          4'h0: cpu_rdata = regs.lcdc;
          // Bit 7 always reads as one
          4'h1: cpu_rdata = {1'b1, regs.stat_enable, regs.coincidence, regs.mode};
          4'h2: cpu_rdata = regs.scy;
          4'h3: cpu_rdata = regs.scx;
          4'h4: cpu_rdata = regs.ly;
          4'h5: cpu_rdata = regs.lyc;
          4'h7: cpu_rdata = regs.bgp;
          4'hA: cpu_rdata = wy;
          4'hB: cpu_rdata = wx;
          default: cpu_rdata = 8'hFF;
        endcase
      end
    end
  end

endmodule

// File: hdl/ppu_timing.sv
`timescale 1ns/100ps
`include "ppu_settings.svh"

module ppu_timing import ppu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  ppu_regs_if.timing  regs,
  input  logic        line_done,
  output logic        flush,
  output logic        vblank_req,
  output logic        stat_req
);

  dot_t      dot;
  byte_t     next_ly;
  logic      lcd_on;
  logic      line_end;
  byte_t     ly_prev;
  ppu_mode_t mode_prev;
  logic      lyc_hit;
  logic      mode_hit;

  assign lcd_on = regs.lcdc[7];
  assign line_end = (dot == dot_t'(`PPU_DOTS_PER_LINE - 1));
  // Line after the current one, wrapping at frame end
  assign next_ly = (regs.ly == byte_t'(`PPU_LINES_PER_FRAME - 1)) ? '0 : regs.ly + 1'b1;

  // ==================================================
  // Dot and line counters
  // ==================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot        <= '0;
      regs.ly    <= '0;
      vblank_req <= 1'b0;
    end else begin
      vblank_req <= 1'b0;
      if (!lcd_on) begin
        // Held at the top of the frame
        dot     <= '0;
        regs.ly <= '0;
      end else if (line_end) begin
        dot     <= '0;
        regs.ly <= next_ly;
        // Pulse on entry to line 144
        if (next_ly == byte_t'(`PPU_VISIBLE_LINES)) vblank_req <= 1'b1;
      end else begin
        dot <= dot + 1'b1;
      end
    end
  end

  // ==================================================
  // Mode FSM
  // ==================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs.mode <= mode_oam_scan;
      flush     <= 1'b0;
    end else begin
      flush <= 1'b0;
      if (!lcd_on) begin
        regs.mode <= mode_oam_scan;
        // Clear a half-finished line
        flush     <= (regs.mode == mode_transfer);
      end else if (line_end) begin
        regs.mode <= (next_ly >= byte_t'(`PPU_VISIBLE_LINES)) ? mode_vblank : mode_oam_scan;
        flush     <= (regs.mode == mode_transfer);
      end else begin
        case (regs.mode)
          mode_oam_scan: begin
            if (dot == dot_t'(`PPU_OAM_SCAN_DOTS - 1)) regs.mode <= mode_transfer;
          end
          // Variable length, ends after the last pixel
          mode_transfer: begin
            if (line_done) begin
              regs.mode <= mode_hblank;
              flush     <= 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // ==================================================
  // Coincidence and STAT interrupt
  // ==================================================
  assign lyc_hit = regs.stat_enable[3] && (regs.ly != ly_prev) && (regs.ly == regs.lyc);
  assign mode_hit = (regs.mode != mode_prev) &&
                    ((regs.stat_enable[2] && regs.mode == mode_oam_scan) ||
                     (regs.stat_enable[1] && regs.mode == mode_vblank) ||
                     (regs.stat_enable[0] && regs.mode == mode_hblank));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs.coincidence <= 1'b0;
      ly_prev          <= '0;
      mode_prev        <= mode_oam_scan;
      stat_req         <= 1'b0;
    end else begin
      regs.coincidence <= (regs.ly == regs.lyc);
      ly_prev          <= regs.ly;
      mode_prev        <= regs.mode;
      // Silent while the display is off
      stat_req         <= lcd_on && (lyc_hit || mode_hit);
    end
  end

endmodule

// File: hdl/bg_fetcher.sv
`timescale 1ns/100ps

module bg_fetcher import ppu_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  ppu_regs_if.reader    regs,
  vram_fetch_if.fetcher fetch,
  pixel_fifo_if.writer  fifo,
  input  logic          flush
);

  fetch_state_t state;
  // Second cycle of a read step
  logic         data_phase;
  logic [4:0]   tile_col;
  byte_t        tile_num;
  tile_row_t    row_buf;
  byte_t        bg_row;
  vram_addr_t   map_addr;
  vram_addr_t   data_addr;
  logic         active;

  assign active = (regs.mode == mode_transfer) && !flush;
  assign bg_row = regs.ly + regs.scy;

  // Tile map at 0x9800 or 0x9C00, 32x32 entries
  assign map_addr = {2'b11, regs.lcdc[3], bg_row[7:3], tile_col};
  // Unsigned from 0x8000 or signed around 0x9000
  assign data_addr = {~regs.lcdc[4] & ~tile_num[7], tile_num, bg_row[2:0],
                      state == fetch_high};

  assign fetch.addr = (state == fetch_tile) ? map_addr : data_addr;
  assign fetch.read_req = active && !data_phase && (state != fetch_push);
  // Only wait point is a full FIFO
  assign fifo.push = active && (state == fetch_push) && fifo.room;
  assign fifo.push_row = row_buf;

  // ==================================================
  // Fetch sequence
  // ==================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= fetch_tile;
      data_phase <= 1'b0;
      tile_col   <= '0;
    end else if (!active) begin
      // Start column follows coarse SCX until transfer begins
      state      <= fetch_tile;
      data_phase <= 1'b0;
      tile_col   <= regs.scx[7:3];
    end else begin
      case (state)
        fetch_push: begin
          if (fifo.room) begin
            state    <= fetch_tile;
            tile_col <= tile_col + 1'b1;
          end
        end
        default: begin
          data_phase <= !data_phase;
          if (data_phase) begin
            case (state)
              fetch_tile: state <= fetch_low;
              fetch_low:  state <= fetch_high;
              default:    state <= fetch_push;
            endcase
          end
        end
      endcase
    end
  end

  // Capture read data
  always_ff @(posedge clk) begin
    if (active && data_phase) begin
      case (state)
        fetch_tile: tile_num <= fetch.rdata;
        fetch_low:  row_buf[7:0] <= fetch.rdata;
        fetch_high: row_buf[15:8] <= fetch.rdata;
        default: ;
      endcase
    end
  end

endmodule

// File: hdl/bg_pixel_fifo.sv
`timescale 1ns/100ps
`include "ppu_settings.svh"

module bg_pixel_fifo import ppu_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  pixel_fifo_if.store  fifo,
  input  logic         flush
);

  localparam int depth   = `PPU_FIFO_DEPTH;
  localparam int count_w = $clog2(depth + 1);

  // Entry 0 is the head
  color_t             store [depth];
  color_t             store_next [depth];
  logic [count_w-1:0] count;
  // Fill level after this cycle's pop
  logic [count_w-1:0] base;
  logic               do_pop;

  assign do_pop = fifo.pop && (count != '0);
  assign fifo.has_pixel = (count != '0);
  // Space for a whole tile row
  assign fifo.room = (count <= count_w'(depth - 8));
  assign fifo.head = store[0];

  // ==================================================
  // Shift and append
  // ==================================================
  always_comb begin
    store_next = store;
    base = count;
    if (do_pop) begin
      for (int i = 0; i < depth - 1; i++) begin
        store_next[i] = store[i + 1];
      end
      base = count - 1'b1;
    end
    // Leftmost pixel goes in first
    if (fifo.push) begin
      for (int i = 0; i < 8; i++) begin
        store_next[int'(base) + i] = {fifo.push_row[15 - i], fifo.push_row[7 - i]};
      end
    end
  end

  always_ff @(posedge clk) begin
    store <= store_next;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (flush) begin
      count <= '0;
    end else begin
      count <= fifo.push ? base + count_w'(8) : base;
    end
  end

endmodule

// File: hdl/pixel_output.sv
`timescale 1ns/100ps
`include "ppu_settings.svh"

module pixel_output import ppu_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  ppu_regs_if.reader   regs,
  pixel_fifo_if.reader fifo,
  input  logic         flush,
  output logic         pixel_valid,
  output color_t       pixel_color,
  output logic         line_done
);

  localparam int screen_width = `PPU_SCREEN_WIDTH;

  // Fine scroll latched at transfer start
  logic [2:0] fine_x;
  logic [2:0] dropped;
  logic [7:0] kept;
  logic       active;
  logic       discard;
  logic       keep;

  assign active = (regs.mode == mode_transfer) && !flush;
  // Stop popping once the line is full
  assign fifo.pop = active && fifo.has_pixel && (kept != 8'(screen_width));
  assign discard = fifo.pop && (dropped != fine_x);
  assign keep = fifo.pop && (dropped == fine_x);

  // ==================================================
  // Per-line counters and strobes
  // ==================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fine_x      <= '0;
      dropped     <= '0;
      kept        <= '0;
      pixel_valid <= 1'b0;
      line_done   <= 1'b0;
    end else begin
      pixel_valid <= keep;
      line_done   <= keep && (kept == 8'(screen_width - 1));
      if (!active) begin
        fine_x  <= regs.scx[2:0];
        dropped <= '0;
        kept    <= '0;
      end else begin
        if (discard) dropped <= dropped + 1'b1;
        if (keep) kept <= kept + 1'b1;
      end
    end
  end

  // BGP lookup, index n uses bits 2n+1:2n
  always_ff @(posedge clk) begin
    if (keep) pixel_color <= regs.bgp[{fifo.head, 1'b0} +: 2];
  end

endmodule

// File: hdl/ppu.sv
`timescale 1ns/100ps

module ppu import ppu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  cpu_addr_t cpu_addr,
  input  byte_t     cpu_wdata,
  input  logic      cpu_write_en,
  input  logic      cpu_read_en,
  output byte_t     cpu_rdata,
  output logic      vblank_req,
  output logic      stat_req,
  output logic      pixel_valid,
  output color_t    pixel_color
);

  // End of line handshake between timing and the pixel path
  logic flush;
  logic line_done;

  ppu_regs_if   regs ();
  vram_fetch_if fetch ();
  pixel_fifo_if fifo ();

  // ==================================================
  // CPU side and timing
  // ==================================================
  ppu_cpu_port i_cpu_port (
    .clk, .reset, .cpu_addr, .cpu_wdata, .cpu_write_en, .cpu_read_en, .cpu_rdata,
    .regs, .fetch
  );

  ppu_timing i_timing (.clk, .reset, .regs, .line_done, .flush, .vblank_req, .stat_req);

  // ==================================================
  // Background pixel path
  // ==================================================
  bg_fetcher i_fetcher (.clk, .reset, .regs, .fetch, .fifo, .flush);

  bg_pixel_fifo i_fifo (.clk, .reset, .fifo, .flush);

  pixel_output i_output (
    .clk, .reset, .regs, .fifo, .flush, .pixel_valid, .pixel_color, .line_done
  );

endmodule

// File: test/ppu_tb.sv
`timescale 1ns/100ps
`include "ppu_settings.svh"

module ppu_tb import ppu_pkg::*; ();

  localparam int frame_cycles = `PPU_DOTS_PER_LINE * `PPU_LINES_PER_FRAME;
  // Four frames plus VRAM fill and register tests
  localparam longint watchdog_ns = longint'(4 * frame_cycles + 20000) * 20;

  logic      clk;
  logic      reset;
  cpu_addr_t cpu_addr;
  byte_t     cpu_wdata;
  logic      cpu_write_en;
  logic      cpu_read_en;
  byte_t     cpu_rdata;
  logic      vblank_req;
  logic      stat_req;
  logic      pixel_valid;
  color_t    pixel_color;

  // VRAM mirror and register copies
  byte_t       mirror [8192];
  byte_t       lcdc_val;
  byte_t       scx_val;
  byte_t       scy_val;
  byte_t       bgp_val;
  byte_t       lyc_val;
  logic [3:0]  en_val;
  logic [31:0] lfsr;

  ppu i_ppu (.*);

  // ==================================================
  // Clock, watchdog, failure path
  // ==================================================
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic fail_now(input string why);
    $display("%s at %0t ns", why, $time);
    $display("Testbench failed");
    $fatal(1);
  endtask

  initial begin
    #(watchdog_ns);
    fail_now("watchdog expired, run did not finish in time");
  end

  task automatic check_value(input string name, input int got, input int expected);
    assert (got == expected) else begin
      $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
      fail_now("value check failed");
    end
  endtask

  // Interrupt lines are single-cycle pulses
  assert property (@(posedge clk) disable iff (reset) vblank_req |=> !vblank_req)
    else fail_now("vblank_req held longer than one cycle");
  assert property (@(posedge clk) disable iff (reset) stat_req |=> !stat_req)
    else fail_now("stat_req held longer than one cycle");

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // ==================================================
  // Bus tasks, called 2 ns after a rising edge
  // ==================================================
  task automatic write_bus(input cpu_addr_t addr, input byte_t data);
    cpu_addr = addr;
    cpu_wdata = data;
    cpu_write_en = 1'b1;
    @(posedge clk);
    #2 cpu_write_en = 1'b0;
  endtask

  task automatic read_bus(input cpu_addr_t addr, output byte_t data);
    cpu_addr = addr;
    cpu_read_en = 1'b1;
    // Sampled mid-cycle where the mux has settled
    @(negedge clk);
    data = cpu_rdata;
    @(posedge clk);
    #2 cpu_read_en = 1'b0;
  endtask

  // Background colour after BGP at screen column x, line y
  function automatic int bg_color(input int x, input int y);
    int px;
    int py;
    int tile;
    int base;
    int b;
    int c;
    px = (x + int'(scx_val)) % 256;
    py = (y + int'(scy_val)) % 256;
    tile = int'(mirror[(lcdc_val[3] ? 'h1C00 : 'h1800) + (py / 8) * 32 + px / 8]);
    if (lcdc_val[4]) begin
      base = tile * 16;
    end else begin
      // Signed tile number around 0x9000
      if (tile > 127) tile = tile - 256;
      base = 'h1000 + tile * 16;
    end
    b = 7 - px % 8;
    c = int'({mirror[base + (py % 8) * 2 + 1][b], mirror[base + (py % 8) * 2][b]});
    return int'(bgp_val[2 * c +: 2]);
  endfunction

  // ==================================================
  // One full frame, mode model against STAT and LY
  // ==================================================
  task automatic run_frame();
    int        dot;
    int        ly;
    int        px;
    int        prev_ly;
    logic      done;
    logic      pending;
    logic      coinc;
    logic      ly_read;
    ppu_mode_t exp_mode;
    ppu_mode_t prev_mode;
    byte_t     stat_exp;
    prev_ly = 0;
    prev_mode = mode_oam_scan;
    pending = 1'b0;
    px = 0;
    done = 1'b0;
    for (int cyc = 0; cyc < frame_cycles; cyc++) begin
      dot = cyc % `PPU_DOTS_PER_LINE;
      ly = cyc / `PPU_DOTS_PER_LINE;
      // LY on both sides of the line step, STAT elsewhere
      ly_read = (dot == 0 || dot == `PPU_DOTS_PER_LINE - 1);
      cpu_addr = ly_read ? 16'hFF44 : 16'hFF41;
      cpu_read_en = 1'b1;
      @(negedge clk);
      if (dot == 0) begin
        px = 0;
        done = 1'b0;
      end
      if (ly >= `PPU_VISIBLE_LINES) exp_mode = mode_vblank;
      else if (dot < `PPU_OAM_SCAN_DOTS) exp_mode = mode_oam_scan;
      else if (!done) exp_mode = mode_transfer;
      else exp_mode = mode_hblank;
      // Flag lags LY by one cycle
      coinc = (prev_ly == int'(lyc_val));
      stat_exp = {1'b1, en_val, coinc, exp_mode};
      if (ly_read) check_value("LY", int'(cpu_rdata), ly);
      else check_value("STAT", int'(cpu_rdata), int'(stat_exp));
      check_value("vblank_req", int'(vblank_req), int'(ly == 144 && dot == 0));
      check_value("stat_req", int'(stat_req), int'(pending));
      pending = (exp_mode != prev_mode &&
                 ((en_val[2] && exp_mode == mode_oam_scan) ||
                  (en_val[1] && exp_mode == mode_vblank) ||
                  (en_val[0] && exp_mode == mode_hblank))) ||
                (en_val[3] && ly != prev_ly && ly == int'(lyc_val));
      if (pixel_valid) begin
        assert (exp_mode == mode_transfer) else
          fail_now("pixel_valid outside of pixel transfer");
        check_value("pixel_color", int'(pixel_color), bg_color(px, ly));
        px++;
        if (px == `PPU_SCREEN_WIDTH) done = 1'b1;
      end
      if (ly < `PPU_VISIBLE_LINES && dot == `PPU_DOTS_PER_LINE - 1) begin
        check_value("pixels per line", px, `PPU_SCREEN_WIDTH);
      end
      prev_ly = ly;
      prev_mode = exp_mode;
      @(posedge clk);
      #2;
    end
    cpu_read_en = 1'b0;
  endtask

  // Scroll, palette and interrupt setup, LCD still off
  task automatic setup_frame(input byte_t lcdc, input logic [3:0] en);
    scx_val = byte_t'(rand_bits(8));
    scy_val = byte_t'(rand_bits(8));
    bgp_val = byte_t'(rand_bits(8));
    lyc_val = byte_t'(rand_bits(8) % 154);
    en_val = en;
    lcdc_val = lcdc;
    write_bus(16'hFF43, scx_val);
    write_bus(16'hFF42, scy_val);
    write_bus(16'hFF47, bgp_val);
    write_bus(16'hFF45, lyc_val);
    write_bus(16'hFF41, {1'b0, en, 3'b000});
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    byte_t      data;
    vram_addr_t va;
    lfsr = 32'd32;
    reset = 1'b1;
    cpu_addr = '0;
    cpu_wdata = '0;
    cpu_write_en = 1'b0;
    cpu_read_en = 1'b0;
    repeat (16) @(posedge clk);
    #2 reset = 1'b0;

    // Register file readback
    write_bus(16'hFF42, 8'h5A);
    read_bus(16'hFF42, data);
    check_value("SCY", int'(data), 'h5A);
    write_bus(16'hFF43, 8'hA5);
    read_bus(16'hFF43, data);
    check_value("SCX", int'(data), 'hA5);
    write_bus(16'hFF47, 8'hE4);
    read_bus(16'hFF47, data);
    check_value("BGP", int'(data), 'hE4);
    write_bus(16'hFF4A, 8'h12);
    read_bus(16'hFF4A, data);
    check_value("WY", int'(data), 'h12);
    write_bus(16'hFF4B, 8'h34);
    read_bus(16'hFF4B, data);
    check_value("WX", int'(data), 'h34);
    write_bus(16'hFF40, 8'h1B);
    read_bus(16'hFF40, data);
    check_value("LCDC", int'(data), 'h1B);
    write_bus(16'hFF45, 8'h99);
    read_bus(16'hFF45, data);
    check_value("LYC", int'(data), 'h99);
    // LY differs from LYC, mode is OAM scan
    write_bus(16'hFF41, 8'hFF);
    read_bus(16'hFF41, data);
    check_value("STAT", int'(data), int'({1'b1, 4'hF, 1'b0, mode_oam_scan}));
    write_bus(16'hFF44, 8'h55);
    read_bus(16'hFF44, data);
    check_value("LY", int'(data), 0);
    read_bus(`PPU_DMA_ADDR, data);
    check_value("DMA read", int'(data), 'hFF);
    read_bus(16'hFF48, data);
    check_value("unmapped FF48", int'(data), 'hFF);
    read_bus(16'hA000, data);
    check_value("unmapped A000", int'(data), 'hFF);
    write_bus(16'hFF40, 8'h00);

    // VRAM fill and sampled readback, LCD off
    for (int i = 0; i < 8192; i++) begin
      mirror[i] = byte_t'(rand_bits(8));
      write_bus(`PPU_VRAM_START + cpu_addr_t'(i), mirror[i]);
    end
    for (int i = 0; i < 64; i++) begin
      va = vram_addr_t'(rand_bits(13));
      read_bus(`PPU_VRAM_START + cpu_addr_t'(va), data);
      check_value("VRAM", int'(data), int'(mirror[va]));
    end

    // Lockout during transfer, on a byte that differs from open bus
    do va = vram_addr_t'(rand_bits(13)); while (mirror[va] == 8'hFF);
    write_bus(16'hFF40, 8'h91);
    do read_bus(16'hFF41, data); while (data[1:0] != mode_transfer);
    read_bus(`PPU_VRAM_START + cpu_addr_t'(va), data);
    check_value("locked VRAM", int'(data), 'hFF);
    write_bus(`PPU_VRAM_START + cpu_addr_t'(va), ~mirror[va]);
    do read_bus(16'hFF41, data); while (data[1:0] != mode_hblank);
    read_bus(`PPU_VRAM_START + cpu_addr_t'(va), data);
    check_value("VRAM after lockout", int'(data), int'(mirror[va]));
    write_bus(16'hFF40, 8'h00);

    // Unsigned tile data, map 0x9800, LYC and HBlank sources
    setup_frame(8'h91, 4'b1001);
    write_bus(16'hFF40, lcdc_val);
    run_frame();
    write_bus(16'hFF40, 8'h00);

    // Signed tile data, map 0x9C00, no STAT sources
    setup_frame(8'h89, 4'b0000);
    write_bus(16'hFF40, lcdc_val);
    run_frame();
    write_bus(16'hFF40, 8'h00);

    // LCD off from HBlank of line 1 with every STAT source enabled
    write_bus(16'hFF45, 8'h00);
    write_bus(16'hFF41, 8'h78);
    write_bus(16'hFF40, 8'h91);
    do read_bus(16'hFF44, data); while (data != 8'd1);
    do read_bus(16'hFF41, data); while (data[1:0] != mode_hblank);
    write_bus(16'hFF40, 8'h00);
    // Counters clear on the following edge
    @(posedge clk);
    #2;
    for (int i = 0; i < 1000; i++) begin
      cpu_addr = 16'hFF44;
      cpu_read_en = 1'b1;
      @(negedge clk);
      check_value("LY", int'(cpu_rdata), 0);
      check_value("pixel_valid", int'(pixel_valid), 0);
      check_value("vblank_req", int'(vblank_req), 0);
      check_value("stat_req", int'(stat_req), 0);
      @(posedge clk);
      #2;
    end
    cpu_read_en = 1'b0;

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: ppu.f
+incdir+hdl
hdl/ppu_pkg.sv
hdl/ppu_ifs.sv
hdl/ppu_cpu_port.sv
hdl/ppu_timing.sv
hdl/bg_fetcher.sv
hdl/bg_pixel_fifo.sv
hdl/pixel_output.sv
hdl/ppu.sv
test/ppu_tb.sv

// File: Makefile
SOURCES = $(wildcard hdl/*.sv hdl/*.svh test/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vppu_tb: ppu.f $(SOURCES)
	verilator --binary --timing --assert --top-module ppu_tb -f ppu.f -o Vppu_tb

run: obj_dir/Vppu_tb
	-./obj_dir/Vppu_tb 2>&1 | tee ppu.log
	@if grep -q "Testbench failed" ppu.log; then exit 1; fi
	@grep -q "Testbench passed" ppu.log

clean:
	rm -rf obj_dir ppu.log
